// File: design/muldiv_data_pkg.sv
package muldiv_data_pkg;

	// MIPS machine word
	localparam int WORD_W = 32;

	// operand, HI or LO value
	typedef logic [WORD_W-1:0] word_t;

	// product, or remainder:quotient
	// upper half always lands in HI
	typedef logic [2*WORD_W-1:0] dword_t;

	// accept edge to commit edge of a divide
	// one load, 32 shift-subtract steps, one sign fix
	localparam int DIV_CYCLES = 34;

	// multiplier latency in edges
	localparam int MUL_STAGES = 2;

endpackage

// File: design/muldiv_ops_pkg.sv
package muldiv_ops_pkg;

	// requested HI/LO operation
	typedef enum logic [2:0] {
		MD_NONE  = 3'd0,
		MD_MULT  = 3'd1,
		MD_MULTU = 3'd2,
		MD_DIV   = 3'd3,
		MD_DIVU  = 3'd4
	} md_op_t;

	// iterative divider states
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,
		DIV_RUN  = 2'd1,
		DIV_FIX  = 2'd2
	} div_state_t;

endpackage

// File: design/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe import muldiv_data_pkg::*, muldiv_ops_pkg::*; (
	input  logic   clk,
	input  logic   reset_i,
	input  logic   op_valid_i,
	input  md_op_t op_i,
	input  word_t  src_a_i,
	input  word_t  src_b_i,
	input  logic   busy_i,
	output logic   mul_valid_o,
	output dword_t mul_result_o
);

	logic               mul_start;
	logic               op_signed;
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [32:0] a_q;
	logic signed [32:0] b_q;
	logic               s1_valid_q;
	logic signed [65:0] prod_full;
	dword_t             prod_q;
	logic               s2_valid_q;

	// only multiplies, and never while the divider holds the unit
	assign mul_start = op_valid_i && !busy_i && (op_i == MD_MULT || op_i == MD_MULTU);
	assign op_signed = (op_i == MD_MULT);

	// a 33rd bit makes MULT and MULTU the same signed multiply
	assign a_ext = $signed({op_signed & src_a_i[31], src_a_i});
	assign b_ext = $signed({op_signed & src_b_i[31], src_b_i});

	// stage one, extended operands
	always_ff @(posedge clk) begin
		if (mul_start) begin
			a_q <= a_ext;
			b_q <= b_ext;
		end
	end

	assign prod_full = a_q * b_q;

	// stage two, the product itself
	always_ff @(posedge clk) begin
		if (s1_valid_q) begin
			prod_q <= prod_full[63:0];
		end
	end

	// valid bits follow the data down the pipe
	always_ff @(posedge clk) begin
		if (reset_i) begin
			s1_valid_q <= 1'b0;
			s2_valid_q <= 1'b0;
		end else begin
			s1_valid_q <= mul_start;
			s2_valid_q <= s1_valid_q;
		end
	end

	assign mul_valid_o  = s2_valid_q;
	assign mul_result_o = prod_q;

endmodule

// File: design/div_iter.sv
`timescale 1ns/1ps

module div_iter import muldiv_data_pkg::*, muldiv_ops_pkg::*; (
	input  logic   clk,
	input  logic   reset_i,
	input  logic   op_valid_i,
	input  md_op_t op_i,
	input  word_t  src_a_i,
	input  word_t  src_b_i,
	output logic   busy_o,
	output logic   div_valid_o,
	output dword_t div_result_o
);

	// load and sign fix take one edge each
	localparam int ITERS = DIV_CYCLES - 2;
	localparam logic [4:0] LAST_STEP = 5'(ITERS - 1);

	div_state_t  state_q;
	logic [4:0]  step_q;
	logic        is_div_op;
	logic        op_signed;
	logic        div_start;
	word_t       a_mag;
	word_t       b_mag;
	word_t       divisor_q;
	word_t       quo_q;
	word_t       rem_q;
	logic        neg_quo_q;
	logic        neg_rem_q;
	logic [32:0] trial;
	word_t       quo_fix;
	word_t       rem_fix;
	dword_t      result_q;
	logic        valid_q;

	assign is_div_op = (op_i == MD_DIV || op_i == MD_DIVU);
	assign op_signed = (op_i == MD_DIV);

	// busy covers the whole run, the fix edge and the cycle the result waits for commit
	assign busy_o    = (state_q != DIV_IDLE) || valid_q;
	assign div_start = op_valid_i && is_div_op && !busy_o;

	// unsigned magnitudes, 0x80000000 stays as it is
	assign a_mag = (op_signed && src_a_i[31]) ? word_t'(-src_a_i) : src_a_i;
	assign b_mag = (op_signed && src_b_i[31]) ? word_t'(-src_b_i) : src_b_i;

	// shift in the next dividend bit and try the subtract
	// bit 32 set means the partial remainder was too small
	assign trial = {rem_q, quo_q[31]} - {1'b0, divisor_q};

	// quotient sign from both operands, remainder follows the dividend
	assign quo_fix = neg_quo_q ? word_t'(-quo_q) : quo_q;
	assign rem_fix = neg_rem_q ? word_t'(-rem_q) : rem_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= DIV_IDLE;
			step_q  <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
				DIV_IDLE: begin
					if (div_start) begin
						state_q <= DIV_RUN;
						step_q  <= '0;
					end
				end
				DIV_RUN: begin
					step_q <= step_q + 5'd1;
					if (step_q == LAST_STEP) begin
						state_q <= DIV_FIX;
					end
				end
				DIV_FIX: begin
					valid_q <= 1'b1;
					state_q <= DIV_IDLE;
				end
				default: state_q <= DIV_IDLE;
			endcase
		end
	end

	// datapath, quotient builds up in the dividend's place
	// a zero divisor always "fits", so the quotient ends all ones
	// and the remainder ends as the dividend magnitude
	always_ff @(posedge clk) begin
		case (state_q)
			DIV_IDLE: begin
				if (div_start) begin
					divisor_q <= b_mag;
					quo_q     <= a_mag;
					rem_q     <= '0;
					neg_quo_q <= op_signed && (src_a_i[31] ^ src_b_i[31]);
					neg_rem_q <= op_signed && src_a_i[31];
				end
			end
			DIV_RUN: begin
				if (!trial[32]) begin
					rem_q <= trial[31:0];
					quo_q <= {quo_q[30:0], 1'b1};
				end else begin
					rem_q <= {rem_q[30:0], quo_q[31]};
					quo_q <= {quo_q[30:0], 1'b0};
				end
			end
			DIV_FIX: begin
				// remainder to HI, quotient to LO
				result_q <= {rem_fix, quo_fix};
			end
			default: begin
				result_q <= result_q;
			end
		endcase
	end

	assign div_valid_o  = valid_q;
	assign div_result_o = result_q;

	// a divide offered while busy must not restart the iteration
	a_no_accept_busy: assert property (@(posedge clk) disable iff (reset_i)
		(op_valid_i && is_div_op && busy_o) |=> !(state_q == DIV_RUN && step_q == '0));

	// busy holds for the full divide, then drops
	a_busy_length: assert property (@(posedge clk) disable iff (reset_i)
		div_start |=> busy_o [*DIV_CYCLES] ##1 !busy_o);

endmodule

// File: design/hilo_commit.sv
`timescale 1ns/1ps

module hilo_commit import muldiv_data_pkg::*; (
	input  logic   clk,
	input  logic   reset_i,
	input  logic   mul_valid_i,
	input  dword_t mul_result_i,
	input  logic   div_valid_i,
	input  dword_t div_result_i,
	output word_t  hi_o,
	output word_t  lo_o,
	output logic   done_o
);

	word_t hi_q;
	word_t lo_q;
	logic  done_q;

	// HI/LO pair, visible to the outside at all times
	always_ff @(posedge clk) begin
		if (reset_i) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (mul_valid_i) begin
			hi_q <= mul_result_i[63:32];
			lo_q <= mul_result_i[31:0];
		end else if (div_valid_i) begin
			hi_q <= div_result_i[63:32];
			lo_q <= div_result_i[31:0];
		end
	end

	// one pulse per commit
	always_ff @(posedge clk) begin
		if (reset_i) begin
			done_q <= 1'b0;
		end else begin
			done_q <= mul_valid_i | div_valid_i;
		end
	end

	assign hi_o   = hi_q;
	assign lo_o   = lo_q;
	assign done_o = done_q;

	// issue rules at the top keep the two sources apart
	a_one_source: assert property (@(posedge clk) disable iff (reset_i)
		!(mul_valid_i && div_valid_i));

endmodule

// File: design/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit import muldiv_data_pkg::*, muldiv_ops_pkg::*; (
	input  logic   clk,
	input  logic   reset_i,
	input  logic   op_valid_i,
	input  md_op_t op_i,
	input  word_t  src_a_i,
	input  word_t  src_b_i,
	output logic   busy_o,
	output logic   done_o,
	output word_t  hi_o,
	output word_t  lo_o
);

	logic   div_busy;
	logic   mul_valid;
	dword_t mul_result;
	logic   div_valid;
	dword_t div_result;

	// divider busy also holds off new multiplies
	assign busy_o = div_busy;

	// two-stage multiplier
	mul_pipe mul_pipe_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.op_valid_i   (op_valid_i),
		.op_i         (op_i),
		.src_a_i      (src_a_i),
		.src_b_i      (src_b_i),
		.busy_i       (div_busy),
		.mul_valid_o  (mul_valid),
		.mul_result_o (mul_result)
	);

	// iterative divider, owns the busy stall
	div_iter div_iter_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.op_valid_i   (op_valid_i),
		.op_i         (op_i),
		.src_a_i      (src_a_i),
		.src_b_i      (src_b_i),
		.busy_o       (div_busy),
		.div_valid_o  (div_valid),
		.div_result_o (div_result)
	);

	// HI/LO registers and done pulse
	hilo_commit hilo_commit_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.mul_valid_i  (mul_valid),
		.mul_result_i (mul_result),
		.div_valid_i  (div_valid),
		.div_result_i (div_result),
		.hi_o         (hi_o),
		.lo_o         (lo_o),
		.done_o       (done_o)
	);

endmodule

// File: tests/muldiv_checks.svh
`ifndef MULDIV_CHECKS_SVH
`define MULDIV_CHECKS_SVH

// one error counter per kind of check
int word_errors  = 0;
int bit_errors   = 0;
int other_errors = 0;

// 32-bit values such as HI and LO
task automatic check_word(input string name, input word_t actual, input word_t expected);
	if (actual !== expected) begin
		word_errors++;
		$display("FAIL time %0t %s: got %08h, expected %08h", $time, name, actual, expected);
	end
endtask

// single-bit status such as busy and done
task automatic check_bit(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		bit_errors++;
		$display("FAIL time %0t %s: got %0b, expected %0b", $time, name, actual, expected);
	end
endtask

// failures that are not a wrong value
task automatic report_problem(input string what);
	other_errors++;
	$display("ERROR time %0t: %s", $time, what);
endtask

function automatic int error_total();
	return word_errors + bit_errors + other_errors;
endfunction

task automatic print_counts();
	$display("errors: %0d word, %0d bit, %0d other", word_errors, bit_errors, other_errors);
endtask

`endif

// File: tests/muldiv_tb.sv
`timescale 1ns/1ps

module muldiv_tb import muldiv_data_pkg::*, muldiv_ops_pkg::*; ();

	localparam int MAX_CASES = 64;
	localparam int FIELDS    = 6;
	localparam int CLK_HALF  = 10;

	// last column of the data file
	localparam logic [31:0] MODE_BURST = 32'd1;
	localparam logic [31:0] MODE_PROBE = 32'd2;

	logic   clk;
	logic   reset_i;
	logic   op_valid_i;
	md_op_t op_i;
	word_t  src_a_i;
	word_t  src_b_i;
	logic   busy_o;
	logic   done_o;
	word_t  hi_o;
	word_t  lo_o;

	logic [31:0] case_mem [0:MAX_CASES*FIELDS-1];
	int          n_cases;

	// reference model of the issue rules, updated at each falling edge
	dword_t exp_q[$];
	int     due_q[$];
	int     cyc             = 0;
	int     busy_until      = -1;
	logic   model_busy_next = 1'b0;
	logic   monitor_on      = 1'b0;
	logic   exp_busy;
	logic   exp_done;
	dword_t exp_pair;

	`include "muldiv_checks.svh"

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	muldiv_unit muldiv_unit_inst (
		.clk        (clk),
		.reset_i    (reset_i),
		.op_valid_i (op_valid_i),
		.op_i       (op_i),
		.src_a_i    (src_a_i),
		.src_b_i    (src_b_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.hi_o       (hi_o),
		.lo_o       (lo_o)
	);

	// all ones in the op column marks the end of the cases
	task automatic load_cases();
		for (int i = 0; i < MAX_CASES*FIELDS; i++) begin
			case_mem[i] = '1;
		end
		$readmemh("tests/muldiv_tests.dat", case_mem);
		n_cases = 0;
		while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS] != '1) begin
			n_cases++;
		end
	endtask

	function automatic logic [31:0] case_field(input int idx, input int col);
		return case_mem[idx*FIELDS + col];
	endfunction

	// called at a rising edge, returns at the next one
	task automatic issue(input int idx, input logic expect_result);
		logic [31:0] op_word;
		op_word = case_field(idx, 0);
		op_valid_i <= 1'b1;
		op_i       <= md_op_t'(op_word[2:0]);
		src_a_i    <= case_field(idx, 1);
		src_b_i    <= case_field(idx, 2);
		if (expect_result) begin
			exp_q.push_back({case_field(idx, 3), case_field(idx, 4)});
		end
		@(posedge clk);
	endtask

	task automatic idle_inputs();
		op_valid_i <= 1'b0;
		op_i       <= MD_NONE;
		src_a_i    <= '0;
		src_b_i    <= '0;
	endtask

	task automatic wait_drained();
		while (due_q.size() != 0 || model_busy_next) begin
			@(posedge clk);
		end
	endtask

	task automatic check_reset_state();
		check_word("hi_o", hi_o, '0);
		check_word("lo_o", lo_o, '0);
		check_bit("busy_o", busy_o, 1'b0);
		check_bit("done_o", done_o, 1'b0);
	endtask

	// multiply offered during a divide, HI/LO must keep the divide result
	task automatic run_probe(input int idx);
		if (!model_busy_next) begin
			report_problem($sformatf("probe line %0d found the divider idle, not sent", idx));
		end else begin
			// offered in the last busy cycle so a wrongly taken multiply lands after the divide
			while (cyc < busy_until) begin
				@(posedge clk);
			end
			issue(idx, 1'b0);
			idle_inputs();
			wait_drained();
			// room for a stray product to reach HI/LO
			repeat (MUL_STAGES) @(posedge clk);
			@(negedge clk);
			check_word("hi_o", hi_o, case_field(idx, 3));
			check_word("lo_o", lo_o, case_field(idx, 4));
			@(posedge clk);
		end
	endtask

	// expected busy and done per cycle, results popped at each done
	always @(negedge clk) begin
		if (monitor_on) begin
			exp_busy = (cyc <= busy_until);
			exp_done = (due_q.size() != 0) && (due_q[0] == cyc);
			check_bit("busy_o", busy_o, exp_busy);
			check_bit("done_o", done_o, exp_done);
			if (exp_done) begin
				due_q.delete(0);
			end
			if (done_o) begin
				if (exp_q.size() == 0) begin
					report_problem("done_o pulsed with no result outstanding");
				end else begin
					exp_pair = exp_q.pop_front();
					check_word("hi_o", hi_o, exp_pair[63:32]);
					check_word("lo_o", lo_o, exp_pair[31:0]);
				end
			end
			// accepted at the coming rising edge
			if (op_valid_i && !exp_busy) begin
				case (op_i)
					MD_MULT, MD_MULTU: begin
						due_q.push_back(cyc + 1 + MUL_STAGES);
					end
					MD_DIV, MD_DIVU: begin
						busy_until = cyc + DIV_CYCLES;
						due_q.push_back(cyc + 1 + DIV_CYCLES);
					end
					default: begin
					end
				endcase
			end
			model_busy_next = (cyc + 1 <= busy_until);
		end
		cyc++;
	end

	initial begin
		int idx;
		reset_i    = 1'b1;
		op_valid_i = 1'b0;
		op_i       = MD_NONE;
		src_a_i    = '0;
		src_b_i    = '0;
		load_cases();
		if (n_cases == 0) begin
			report_problem("no test cases found in the data file");
		end
		repeat (10) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		check_reset_state();
		@(posedge clk);
		monitor_on = 1'b1;
		idx = 0;
		while (idx < n_cases) begin
			if (case_field(idx, 5) == MODE_BURST) begin
				wait_drained();
				while (idx < n_cases && case_field(idx, 5) == MODE_BURST) begin
					issue(idx, 1'b1);
					idx++;
				end
				idle_inputs();
			end else if (case_field(idx, 5) == MODE_PROBE) begin
				run_probe(idx);
				idx++;
			end else begin
				wait_drained();
				issue(idx, 1'b1);
				idle_inputs();
				idx++;
			end
		end
		wait_drained();
		// a few idle cycles to catch a stray done
		repeat (4) @(posedge clk);
		print_counts();
		if (error_total() == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// watchdog, budget grows with the number of cases
	initial begin
		int budget;
		@(posedge clk);
		budget = n_cases * 40 + 100;
		repeat (budget) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", budget);
		print_counts();
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: tests/muldiv_tests.dat
// columns: op a b expected_hi expected_lo mode, all hex
// op 1=MULT 2=MULTU 3=DIV 4=DIVU, mode 0=wait for done 1=burst 2=sent while busy
2 00000003 00000005 00000000 0000000F 0
2 FFFFFFFF FFFFFFFF FFFFFFFE 00000001 0
1 FFFFFFFF FFFFFFFF 00000000 00000001 0
1 FFFFFFFE 00000003 FFFFFFFF FFFFFFFA 0
1 80000000 80000000 40000000 00000000 0
2 80000000 00000002 00000001 00000000 0
1 7FFFFFFF 80000000 C0000000 80000000 0
2 0000FFFF 0000FFFF 00000000 FFFE0001 0
2 12345678 00000010 00000001 23456780 0
1 12345678 FFFFFFF0 FFFFFFFE DCBA9880 0
1 00000007 FFFFFFF9 FFFFFFFF FFFFFFCF 0
2 FFFFFFF9 00000007 00000006 FFFFFFCF 0
1 00000000 12345678 00000000 00000000 0
// four multiplies back to back
2 00000002 00000003 00000000 00000006 1
1 FFFFFFFF 00000005 FFFFFFFF FFFFFFFB 1
2 00010000 00010000 00000001 00000000 1
1 80000000 00000001 FFFFFFFF 80000000 1
// divides, remainder in HI and quotient in LO
4 00000064 00000007 00000002 0000000E 0
2 00000003 00000003 00000002 0000000E 2
3 FFFFFF9C 00000007 FFFFFFFE FFFFFFF2 0
3 00000064 FFFFFFF9 00000002 FFFFFFF2 0
3 FFFFFF9C FFFFFFF9 FFFFFFFE 0000000E 0
3 80000000 FFFFFFFF 00000000 80000000 0
1 FFFFFFFF FFFFFFFF 00000000 80000000 2
4 FFFFFFFF 00000010 0000000F 0FFFFFFF 0
4 80000000 FFFFFFFF 80000000 00000000 0
4 12345678 00000001 00000000 12345678 0
4 00000005 0000000A 00000005 00000000 0
3 80000000 00000002 00000000 C0000000 0
// division by zero
4 12345678 00000000 12345678 FFFFFFFF 0
3 00000064 00000000 00000064 FFFFFFFF 0
3 FFFFFF9C 00000000 FFFFFF9C 00000001 0
3 80000000 00000000 80000000 00000001 0
// three more back to back
2 FFFFFFFF 00000002 00000001 FFFFFFFE 1
1 40000000 00000004 00000001 00000000 1
1 FFFF0000 00010000 FFFFFFFF 00000000 1
2 00000001 00000001 00000000 00000001 0
// multiply then divide on consecutive cycles, then a multiply while busy
2 00000006 00000007 00000000 0000002A 1
4 000003E8 00000003 00000001 0000014D 1
1 00000002 00000002 00000001 0000014D 2

// File: list.f
+incdir+tests
design/muldiv_data_pkg.sv
design/muldiv_ops_pkg.sv
design/mul_pipe.sv
design/div_iter.sv
design/hilo_commit.sv
design/muldiv_unit.sv
tests/muldiv_tb.sv

// File: run.sh
#!/bin/sh
# build the muldiv testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/muldiv_sim

verilator --binary --timing --assert -sv -Wno-fatal \
	--top-module muldiv_tb --Mdir obj_dir -o muldiv_sim -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
	exit 1
fi
if ! grep -q -F '*** PASSED ***' "$LOG"; then
	echo "no pass message found in $LOG"
	exit 1
fi
exit 0
